// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_id_stage
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dec_1ri20.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_1ri20 (
    input  wire decode_pkg::word_t          inst,
    output logic                            hit,
    output decode_pkg::decode_result_t      result
);
    import decode_pkg::*;

    localparam logic [6:0] op_lu12i     = 7'h0a;
    localparam logic [6:0] op_pcaddu12i = 7'h0e;

    always_comb begin
        result = '0;
        hit    = 1'b1;
        case (inst[31:25])
            op_lu12i:     result.aluop = alu_lu12i;
            op_pcaddu12i: result.aluop = alu_pcaddu12i;
            default:      hit = 1'b0;
        endcase
        if (hit) begin
            result.alusel         = sel_arith;
            result.imm            = {inst[24:5], 12'b0};   // upper 20 bits
            result.reg_write_en   = 1'b1;
            result.reg_write_addr = inst[4:0];
        end
    end

endmodule

`default_nettype wire

// ==== dec_2ri12.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_2ri12 (
    input  wire decode_pkg::word_t          inst,
    output logic                            hit,
    output decode_pkg::decode_result_t      result
);
    import decode_pkg::*;

    localparam logic [9:0] op_slti = 10'h008;
    localparam logic [9:0] op_addi = 10'h00a;
    localparam logic [9:0] op_andi = 10'h00d;
    localparam logic [9:0] op_ori  = 10'h00e;
    localparam logic [9:0] op_ld_w = 10'h0a2;
    localparam logic [9:0] op_st_w = 10'h0a6;

    reg_addr_t rd, rj;
    word_t     imm_sext, imm_zext;

    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign imm_sext = {{20{inst[21]}}, inst[21:10]};
    assign imm_zext = {20'b0, inst[21:10]};

    always_comb begin
        result = '0;
        hit    = 1'b1;
        case (inst[31:22])
            op_slti: begin result.aluop = alu_slt;     result.alusel = sel_arith; end
            op_addi: begin result.aluop = alu_add;     result.alusel = sel_arith; end
            op_andi: begin result.aluop = alu_and;     result.alusel = sel_logic; end
            op_ori:  begin result.aluop = alu_or;      result.alusel = sel_logic; end
            op_ld_w: begin result.aluop = alu_load_w;  result.alusel = sel_mem;   end
            op_st_w: begin result.aluop = alu_store_w; result.alusel = sel_mem;   end
            default: hit = 1'b0;
        endcase
        if (hit) begin
            result.imm            = (result.alusel == sel_logic) ? imm_zext : imm_sext;
            result.reg1_read_en   = 1'b1;
            result.reg1_read_addr = rj;
            if (result.aluop == alu_store_w) begin
                result.reg2_read_en   = 1'b1;   // store data comes from rd
                result.reg2_read_addr = rd;
            end else begin
                result.reg_write_en   = 1'b1;
                result.reg_write_addr = rd;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dec_3r.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_3r (
    input  wire decode_pkg::word_t          inst,
    output logic                            hit,
    output decode_pkg::decode_result_t      result
);
    import decode_pkg::*;

    localparam logic [16:0] op_add     = 17'h00020;
    localparam logic [16:0] op_sub     = 17'h00022;
    localparam logic [16:0] op_slt     = 17'h00024;
    localparam logic [16:0] op_and     = 17'h00029;
    localparam logic [16:0] op_or      = 17'h0002a;
    localparam logic [16:0] op_xor     = 17'h0002b;
    localparam logic [16:0] op_break   = 17'h00054;
    localparam logic [16:0] op_syscall = 17'h00056;

    reg_addr_t rd, rj, rk;
    logic      uses_regs;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    always_comb begin
        result    = '0;
        hit       = 1'b1;
        uses_regs = 1'b1;
        case (inst[31:15])
            op_add: begin result.aluop = alu_add; result.alusel = sel_arith; end
            op_sub: begin result.aluop = alu_sub; result.alusel = sel_arith; end
            op_slt: begin result.aluop = alu_slt; result.alusel = sel_arith; end
            op_and: begin result.aluop = alu_and; result.alusel = sel_logic; end
            op_or:  begin result.aluop = alu_or;  result.alusel = sel_logic; end
            op_xor: begin result.aluop = alu_xor; result.alusel = sel_logic; end
            op_syscall: begin result.aluop = alu_syscall; uses_regs = 1'b0; end
            op_break:   begin result.aluop = alu_break;   uses_regs = 1'b0; end
            default: begin
                hit       = 1'b0;
                uses_regs = 1'b0;
            end
        endcase
        if (uses_regs) begin
            result.reg1_read_en   = 1'b1;
            result.reg1_read_addr = rj;
            result.reg2_read_en   = 1'b1;
            result.reg2_read_addr = rk;
            result.reg_write_en   = 1'b1;
            result.reg_write_addr = rd;
        end
    end

endmodule

`default_nettype wire

// ==== dec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_branch (
    input  wire decode_pkg::word_t          inst,
    output logic                            hit,
    output decode_pkg::decode_result_t      result
);
    import decode_pkg::*;

    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

    localparam reg_addr_t link_reg = 5'd1;   // bl return address

    reg_addr_t rd, rj;
    word_t     offs16, offs26;

    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        result        = '0;
        result.alusel = sel_branch;
        hit           = 1'b1;
        case (inst[31:26])
            op_jirl: begin
                result.aluop          = alu_jirl;
                result.imm            = offs16;
                result.reg1_read_en   = 1'b1;
                result.reg1_read_addr = rj;
                result.reg_write_en   = 1'b1;
                result.reg_write_addr = rd;
            end
            op_b: begin
                result.aluop = alu_b;
                result.imm   = offs26;
            end
            op_bl: begin
                result.aluop          = alu_bl;
                result.imm            = offs26;
                result.reg_write_en   = 1'b1;
                result.reg_write_addr = link_reg;
            end
            op_beq, op_bne: begin
                result.aluop          = (inst[26]) ? alu_bne : alu_beq;
                result.imm            = offs16;
                result.reg1_read_en   = 1'b1;
                result.reg1_read_addr = rj;
                result.reg2_read_en   = 1'b1;   // compare against rd
                result.reg2_read_addr = rd;
            end
            default: begin
                hit    = 1'b0;
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;        // inst, pc or immediate
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  exc_code_t;

    typedef enum logic [7:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_slt,
        alu_and,
        alu_or,
        alu_xor,
        alu_lu12i,
        alu_pcaddu12i,
        alu_load_w,
        alu_store_w,
        alu_beq,
        alu_bne,
        alu_b,
        alu_bl,
        alu_jirl,
        alu_syscall,
        alu_break
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop,
        sel_arith,
        sel_logic,
        sel_mem,
        sel_branch
    } alu_sel_e;

    localparam exc_code_t exc_none = 7'h00;
    localparam exc_code_t exc_sys  = 7'h0b;
    localparam exc_code_t exc_brk  = 7'h0c;
    localparam exc_code_t exc_ine  = 7'h0d;   // instruction not exist

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      pre_taken;
        word_t     pre_addr;
        logic [1:0] fetch_exc;
        exc_code_t pc_exc_cause;
        exc_code_t ib_exc_cause;
    } fetch_bundle_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     imm;
        logic      reg1_read_en;
        logic      reg2_read_en;
        reg_addr_t reg1_read_addr;
        reg_addr_t reg2_read_addr;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
    } decode_result_t;

    typedef struct packed {
        word_t          pc;
        word_t          inst;
        decode_result_t dec;
        logic [2:0]     is_exception;   // fetch bits, then decoder bit
        exc_code_t      pc_exc_cause;
        exc_code_t      ib_exc_cause;
        exc_code_t      dec_exc_cause;
        logic           pre_taken;
        word_t          pre_addr;
    } id_bundle_t;

endpackage

`default_nettype wire

// ==== decode_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_select (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             valid,
    input  wire decode_pkg::fetch_bundle_t  fetch,
    input  wire                             hit_3r,
    input  wire                             hit_2ri12,
    input  wire                             hit_1ri20,
    input  wire                             hit_branch,
    input  wire decode_pkg::decode_result_t res_3r,
    input  wire decode_pkg::decode_result_t res_2ri12,
    input  wire decode_pkg::decode_result_t res_1ri20,
    input  wire decode_pkg::decode_result_t res_branch,
    output logic                            id_valid,
    output decode_pkg::id_bundle_t          id_out
);
    import decode_pkg::*;

    logic [3:0]     hits;
    logic           ine;
    logic           dec_exc;
    exc_code_t      dec_cause;
    decode_result_t sel;
    id_bundle_t     id_next;

    assign hits = {hit_branch, hit_1ri20, hit_2ri12, hit_3r};

    always_comb begin
        sel = '0;
        ine = 1'b0;
        case (hits)
            4'b0001: sel = res_3r;
            4'b0010: sel = res_2ri12;
            4'b0100: sel = res_1ri20;
            4'b1000: sel = res_branch;
            default: ine = 1'b1;     // none or several matched
        endcase

        if (ine)                          dec_cause = exc_ine;
        else if (sel.aluop == alu_syscall) dec_cause = exc_sys;
        else if (sel.aluop == alu_break)   dec_cause = exc_brk;
        else                              dec_cause = exc_none;
        dec_exc = ine || (sel.aluop == alu_syscall) || (sel.aluop == alu_break);

        id_next.pc            = fetch.pc;
        id_next.inst          = ine ? '0 : fetch.inst;
        id_next.dec           = sel;
        id_next.is_exception  = {fetch.fetch_exc, dec_exc};
        id_next.pc_exc_cause  = fetch.pc_exc_cause;
        id_next.ib_exc_cause  = fetch.ib_exc_cause;
        id_next.dec_exc_cause = dec_cause;
        id_next.pre_taken     = fetch.pre_taken;
        id_next.pre_addr      = fetch.pre_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else begin
            id_valid <= valid;
            id_out   <= id_next;
        end
    end

    // format decoders never overlap
    a_hits_onehot: assert property (@(posedge clk) disable iff (reset)
        valid |-> $onehot0(hits));

    a_valid_after_reset: assert property (@(posedge clk) reset |=> !id_valid);

    a_dec_exc_cause: assert property (@(posedge clk) disable iff (reset)
        id_out.is_exception[0] == (id_out.dec_exc_cause != exc_none));

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            valid,
    input  wire decode_pkg::fetch_bundle_t fetch,
    output logic                           id_valid,
    output decode_pkg::id_bundle_t         id_out
);
    import decode_pkg::*;

    logic           hit_3r, hit_2ri12, hit_1ri20, hit_branch;
    decode_result_t res_3r, res_2ri12, res_1ri20, res_branch;

    dec_3r     u_dec_3r     (.inst(fetch.inst), .hit(hit_3r),     .result(res_3r));
    dec_2ri12  u_dec_2ri12  (.inst(fetch.inst), .hit(hit_2ri12),  .result(res_2ri12));
    dec_1ri20  u_dec_1ri20  (.inst(fetch.inst), .hit(hit_1ri20),  .result(res_1ri20));
    dec_branch u_dec_branch (.inst(fetch.inst), .hit(hit_branch), .result(res_branch));

    decode_select u_decode_select (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .fetch      (fetch),
        .hit_3r     (hit_3r),
        .hit_2ri12  (hit_2ri12),
        .hit_1ri20  (hit_1ri20),
        .hit_branch (hit_branch),
        .res_3r     (res_3r),
        .res_2ri12  (res_2ri12),
        .res_1ri20  (res_1ri20),
        .res_branch (res_branch),
        .id_valid   (id_valid),
        .id_out     (id_out)
    );

endmodule

`default_nettype wire

// ==== id_testdata.hex ====
// tag valid pc inst pre_taken pre_addr fetch_exc pc_cause ib_cause, then expected:
// id_valid inst aluop alusel imm r1_en r1 r2_en r2 wr_en wr dec_exc dec_cause
00 0 1c000000 00100c41 0 1c000004 0 00 00 0 00100c41 01 1 00000000 1 02 1 03 1 01 0 00
01 1 1c000004 00100c41 0 1c000008 0 00 00 1 00100c41 01 1 00000000 1 02 1 03 1 01 0 00
02 1 1c000008 00111486 0 1c00000c 0 00 00 1 00111486 02 1 00000000 1 04 1 05 1 06 0 00
03 1 1c00000c 00127fdd 0 1c000010 0 00 00 1 00127fdd 03 1 00000000 1 1e 1 1f 1 1d 0 00
04 1 1c000010 0014a0e9 0 1c000014 0 00 00 1 0014a0e9 04 2 00000000 1 07 1 08 1 09 0 00
05 1 1c000014 0015040c 0 1c000018 0 00 00 1 0015040c 05 2 00000000 1 00 1 01 1 0c 0 00
06 1 1c000018 0015a96d 0 1c00001c 0 00 00 1 0015a96d 06 2 00000000 1 0b 1 0a 1 0d 0 00
07 1 1c00001c 002b0005 0 1c000020 0 00 00 1 002b0005 10 0 00000000 0 00 0 00 0 00 1 0b
08 1 1c000020 002a0001 0 1c000024 2 08 00 1 002a0001 11 0 00000000 0 00 0 00 0 00 1 0c
09 1 1c000024 02a00464 0 1c000028 0 00 00 1 02a00464 01 1 fffff801 1 03 0 00 1 04 0 00
0a 1 1c000028 0201fca6 0 1c00002c 0 00 00 1 0201fca6 03 1 0000007f 1 05 0 00 1 06 0 00
0b 1 1c00002c 037ffce8 0 1c000030 0 00 00 1 037ffce8 04 2 00000fff 1 07 0 00 1 08 0 00
0c 1 1c000030 03a0012a 0 1c000034 0 00 00 1 03a0012a 05 2 00000800 1 09 0 00 1 0a 0 00
0d 1 1c000034 28804043 0 1c000038 0 00 00 1 28804043 09 3 00000010 1 02 0 00 1 03 0 00
0e 1 1c000038 29bff045 0 1c00003c 0 00 00 1 29bff045 0a 3 fffffffc 1 02 1 05 0 00 0 00
0f 0 1c00003c 00000000 1 12345678 3 08 7f 0 00000000 00 0 00000000 0 00 0 00 0 00 1 0d
10 1 1c000040 142468a7 0 1c000044 0 00 00 1 142468a7 07 1 12345000 0 00 0 00 1 07 0 00
11 1 1c000044 1dffffff 0 1c000048 0 00 00 1 1dffffff 08 1 fffff000 0 00 0 00 1 1f 0 00
12 1 1c000048 4c001022 1 1c000100 0 00 00 1 4c001022 0f 4 00000010 1 01 0 00 1 02 0 00
13 1 1c00004c 5bfffc85 1 1c000048 0 00 00 1 5bfffc85 0b 4 fffffffc 1 04 1 05 0 00 0 00
14 1 1c000050 5e0000c7 0 1c000054 0 00 00 1 5e0000c7 0c 4 fffe0000 1 06 1 07 0 00 0 00
15 1 1c000054 50040000 1 1c000454 0 00 00 1 50040000 0d 4 00000400 0 00 0 00 0 00 0 00
16 1 1c000058 57fffbff 1 1c000050 1 00 21 1 57fffbff 0e 4 fffffff8 0 00 0 00 1 01 0 00
17 1 1c00005c 04000c05 0 1c000060 1 00 21 1 00000000 00 0 00000000 0 00 0 00 0 00 1 0d
18 1 1c000060 ffffffff 0 1c000064 0 00 00 1 00000000 00 0 00000000 0 00 0 00 0 00 1 0d

// ==== sim.f ====
decode_pkg.sv
dec_3r.sv
dec_2ri12.sv
dec_1ri20.sv
dec_branch.sv
decode_select.sv
id_stage.sv
tb_id_stage.sv

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import decode_pkg::*;

    localparam int num_vectors = 25;
    localparam int num_cols    = 22;
    localparam int col_tag = 0, col_valid = 1, col_pc = 2, col_inst = 3, col_ptk = 4;
    localparam int col_paddr = 5, col_fexc = 6, col_pcc = 7, col_ibc = 8, col_evld = 9;
    localparam int col_einst = 10, col_eop = 11, col_esel = 12, col_eimm = 13;
    localparam int col_r1e = 14, col_r1a = 15, col_r2e = 16, col_r2a = 17;
    localparam int col_we = 18, col_wa = 19, col_eexc = 20, col_ecause = 21;

    logic          clk;
    logic          reset;
    logic          valid;
    fetch_bundle_t fetch;
    logic          id_valid;
    id_bundle_t    id_out;
    logic [31:0]   vectors [0:num_vectors*num_cols-1];

    id_stage id_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .valid    (valid),
        .fetch    (fetch),
        .id_valid (id_valid),
        .id_out   (id_out)
    );

    always #50 clk = ~clk;

    function automatic string vector_name(input logic [7:0] tag);
        case (tag)
            8'h00: return "idle_add";
            8'h01: return "add_w";
            8'h02: return "sub_w";
            8'h03: return "slt";
            8'h04: return "and";
            8'h05: return "or";
            8'h06: return "xor";
            8'h07: return "syscall";
            8'h08: return "break_fetch_exc";
            8'h09: return "addi_w_neg";
            8'h0a: return "slti";
            8'h0b: return "andi_zext";
            8'h0c: return "ori_zext";
            8'h0d: return "ld_w";
            8'h0e: return "st_w";
            8'h0f: return "idle_zero_inst";
            8'h10: return "lu12i_w";
            8'h11: return "pcaddu12i";
            8'h12: return "jirl";
            8'h13: return "beq_back";
            8'h14: return "bne_far";
            8'h15: return "b_fwd";
            8'h16: return "bl_back";
            8'h17: return "csrrd_ine";
            8'h18: return "all_ones_ine";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [191:0] expected, input logic [191:0] actual);
        assert (actual === expected) else begin
            $display("Error %s: %s expected %h actual %h", test, field, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base = idx * num_cols;
        valid              <= vectors[base + col_valid][0];
        fetch.pc           <= vectors[base + col_pc];
        fetch.inst         <= vectors[base + col_inst];
        fetch.pre_taken    <= vectors[base + col_ptk][0];
        fetch.pre_addr     <= vectors[base + col_paddr];
        fetch.fetch_exc    <= vectors[base + col_fexc][1:0];
        fetch.pc_exc_cause <= vectors[base + col_pcc][6:0];
        fetch.ib_exc_cause <= vectors[base + col_ibc][6:0];
    endtask

    task automatic check_vector(input int idx);
        int         base;
        string      name;
        logic       want_valid;
        id_bundle_t want;
        base       = idx * num_cols;
        name       = vector_name(vectors[base + col_tag][7:0]);
        want_valid = vectors[base + col_evld][0];
        want.pc                 = vectors[base + col_pc];   // pass-through fields
        want.inst               = vectors[base + col_einst];
        want.dec.aluop          = alu_op_e'(vectors[base + col_eop][7:0]);
        want.dec.alusel         = alu_sel_e'(vectors[base + col_esel][2:0]);
        want.dec.imm            = vectors[base + col_eimm];
        want.dec.reg1_read_en   = vectors[base + col_r1e][0];
        want.dec.reg1_read_addr = vectors[base + col_r1a][4:0];
        want.dec.reg2_read_en   = vectors[base + col_r2e][0];
        want.dec.reg2_read_addr = vectors[base + col_r2a][4:0];
        want.dec.reg_write_en   = vectors[base + col_we][0];
        want.dec.reg_write_addr = vectors[base + col_wa][4:0];
        want.is_exception  = {vectors[base + col_fexc][1:0], vectors[base + col_eexc][0]};
        want.pc_exc_cause  = vectors[base + col_pcc][6:0];
        want.ib_exc_cause  = vectors[base + col_ibc][6:0];
        want.dec_exc_cause = vectors[base + col_ecause][6:0];
        want.pre_taken     = vectors[base + col_ptk][0];
        want.pre_addr      = vectors[base + col_paddr];
        check_value(name, "id_valid", 192'(want_valid), 192'(id_valid));
        check_value(name, "decode result", 192'(want.dec), 192'(id_out.dec));
        check_value(name, "is_exception", 192'(want.is_exception), 192'(id_out.is_exception));
        check_value(name, "dec_exc_cause", 192'(want.dec_exc_cause),
                    192'(id_out.dec_exc_cause));
        check_value(name, "inst", 192'(want.inst), 192'(id_out.inst));
        check_value(name, "pc", 192'(want.pc), 192'(id_out.pc));
        check_value(name, "pre_taken", 192'(want.pre_taken), 192'(id_out.pre_taken));
        check_value(name, "pre_addr", 192'(want.pre_addr), 192'(id_out.pre_addr));
        check_value(name, "pc_exc_cause", 192'(want.pc_exc_cause), 192'(id_out.pc_exc_cause));
        check_value(name, "ib_exc_cause", 192'(want.ib_exc_cause), 192'(id_out.ib_exc_cause));
    endtask

    initial begin
        #((num_vectors + 10) * 100);
        $display("timeout, the run did not finish within %0d ns", (num_vectors + 10) * 100);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk   = 1'b0;
        reset <= 1'b1;
        valid <= 1'b0;
        fetch <= '0;
        $readmemh("id_testdata.hex", vectors);
        assert (!$isunknown(vectors[num_vectors*num_cols-1])) else begin
            $display("the test data file id_testdata.hex is missing or too short");
            $display("*** FAILED ***");
            $fatal(1, "no test data");
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        apply_vector(0);
        @(negedge clk);
        check_value("reset", "id_valid", 192'b0, 192'(id_valid));
        check_value("reset", "id_out", 192'b0, 192'(id_out));
        for (int i = 0; i < num_vectors; i++) begin
            @(posedge clk);   // vector i captured here
            if (i + 1 < num_vectors) begin
                apply_vector(i + 1);
            end else begin
                valid <= 1'b0;
                fetch <= '0;
            end
            @(negedge clk);
            check_vector(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
